// ==== logic/icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// fetch address width, byte address
`define ICACHE_ADDR_W   32

// 16 sets
`define ICACHE_INDEX_W  4

// two ways, one lru bit per set
`define ICACHE_WAYS     2

// one 32-bit word per line, so only the two byte bits sit below the index
`define ICACHE_TAG_W    (`ICACHE_ADDR_W - `ICACHE_INDEX_W - 2)

`endif

// ==== logic/icache_ctrl.sv ====
`include "icache_config.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    fetch_valid,
    input  logic                    stall,
    input  logic                    flush,
    output logic                    ready,
    input  icache_op_e              rbuf_op,
    input  logic [`ICACHE_WAYS-1:0] hit,
    input  logic                    victim,
    input  logic                    addr_ok,
    input  logic                    data_ok,
    output logic                    mem_req,
    output logic                    rbuf_we,
    output logic [`ICACHE_WAYS-1:0] way_we,
    output logic                    inv_set,
    output logic                    use0,
    output logic                    use1,
    output logic                    sel_way,
    output logic                    sel_refill,
    output logic                    send_nop,
    output logic                    resp_valid
);

    icache_state_e state_q;
    icache_state_e state;       // decoded state, see below
    icache_state_e next_state;
    logic          rstn_q;
    logic          any_hit;
    logic          can_take;

    // keeps ready low in the first cycle after reset release
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rstn_q <= 1'b0;
        end else begin
            rstn_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= next_state;
        end
    end

    // every accept lands in ST_LOOKUP; the op is only known once it sits in
    // the request buffer, so a buffered invalidate turns that cycle into ST_OP
    assign state = (state_q == ST_LOOKUP && rbuf_op == OP_INVALIDATE) ? ST_OP : state_q;

    assign any_hit  = |hit;
    assign can_take = rstn_q & ~stall;

    ////////////////////////////////////////////////////////////////////////////
    // acceptance
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            ST_IDLE:   ready = can_take;
            ST_LOOKUP: ready = can_take & any_hit & ~flush;  // back to back on a hit
            default:   ready = 1'b0;
        endcase
    end

    assign rbuf_we = ready & fetch_valid;

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (rbuf_we) begin
                    next_state = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (flush) begin
                    next_state = ST_FLUSH;
                end else if (!any_hit) begin
                    // address may be taken in the very first miss cycle
                    next_state = addr_ok ? ST_MISS_WAIT : ST_MISS_REQ;
                end else begin
                    next_state = rbuf_we ? ST_LOOKUP : ST_IDLE;
                end
            end
            ST_MISS_REQ: begin
                if (addr_ok) begin
                    next_state = ST_MISS_WAIT;
                end
            end
            ST_MISS_WAIT: begin
                if (data_ok) begin
                    next_state = ST_IDLE;
                end
            end
            ST_FLUSH: begin
                if (!flush) begin
                    next_state = ST_IDLE;
                end
            end
            ST_OP:   next_state = ST_IDLE;  // single cycle
            default: next_state = ST_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // output decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_req    = 1'b0;
        way_we     = '0;
        inv_set    = 1'b0;
        use0       = 1'b0;
        use1       = 1'b0;
        sel_way    = 1'b0;
        sel_refill = 1'b0;
        send_nop   = 1'b0;
        resp_valid = 1'b0;
        case (state)
            ST_LOOKUP: begin
                if (flush) begin
                    // drop the lookup, answer with a nop
                    resp_valid = 1'b1;
                    send_nop   = 1'b1;
                end else if (!any_hit) begin
                    mem_req = 1'b1;
                end else begin
                    resp_valid = 1'b1;
                    sel_way    = hit[1];
                    use0       = hit[0];
                    use1       = hit[1];
                end
            end
            ST_MISS_REQ: begin
                mem_req = 1'b1;  // held through the addr_ok cycle
            end
            ST_MISS_WAIT: begin
                if (data_ok) begin
                    // fill the lru victim and forward the word
                    resp_valid = 1'b1;
                    sel_refill = 1'b1;
                    way_we     = {victim, ~victim};
                    use0       = ~victim;
                    use1       = victim;
                end
            end
            ST_OP: begin
                inv_set = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== logic/icache_lru.sv ====
`include "icache_config.svh"

module icache_lru
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  index_t index,
    input  logic   use0,
    input  logic   use1,
    output logic   victim
);

    localparam int SETS = 1 << `ICACHE_INDEX_W;

    // 1 means way 1 is the least recently used
    logic [SETS-1:0] lru_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use0) begin
            lru_q[index] <= 1'b1;  // point at the other way
        end else if (use1) begin
            lru_q[index] <= 1'b0;
        end
    end

    assign victim = lru_q[index];

endmodule

// ==== logic/icache_pkg.sv ====
`include "icache_config.svh"

package icache_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS_REQ,   // mem_req up, waiting for addr_ok
        ST_MISS_WAIT,  // waiting for data_ok
        ST_FLUSH,
        ST_OP
    } icache_state_e;

    typedef enum logic {
        OP_FETCH,
        OP_INVALIDATE  // clears both ways of one set
    } icache_op_e;

    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [31:0]                word_t;

    // request from the fetch stage
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        icache_op_e                op;
    } fetch_req_t;

    // response back to the fetch stage
    typedef struct packed {
        word_t data;
        logic  nop;     // lookup dropped by flush
        logic  refill;  // word came from memory
    } icache_resp_t;

endpackage

// ==== logic/icache_req_buf.sv ====
`include "icache_config.svh"

module icache_req_buf
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      rbuf_we,
    input  fetch_req_t                fetch_req,
    output icache_op_e                rbuf_op,
    output index_t                    index,
    output tag_t                      tag,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,
    input  word_t                     way0_data,
    input  word_t                     way1_data,
    input  word_t                     mem_rdata,
    input  logic                      sel_way,
    input  logic                      sel_refill,
    input  logic                      send_nop,
    output icache_resp_t              resp
);

    logic [`ICACHE_ADDR_W-1:0] addr_q;
    icache_op_e                op_q;
    word_t                     hit_data;

    // buffered op for the controller
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            op_q <= OP_FETCH;
        end else if (rbuf_we) begin
            op_q <= fetch_req.op;
        end
    end

    always_ff @(posedge clk) begin
        if (rbuf_we) begin
            addr_q <= fetch_req.addr;
        end
    end

    assign rbuf_op  = op_q;
    assign index    = addr_q[`ICACHE_INDEX_W+1:2];
    assign tag      = addr_q[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W+2];
    assign mem_addr = {addr_q[`ICACHE_ADDR_W-1:2], 2'b00};  // word aligned

    // response mux
    assign hit_data = sel_way ? way1_data : way0_data;

    always_comb begin
        resp.nop    = send_nop;
        resp.refill = sel_refill & ~send_nop;
        if (send_nop) begin
            resp.data = '0;
        end else if (sel_refill) begin
            resp.data = mem_rdata;  // forwarded from memory
        end else begin
            resp.data = hit_data;
        end
    end

endmodule

// ==== logic/icache_top.sv ====
`include "icache_config.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rstn,
    // fetch side
    input  logic                      fetch_valid,
    input  fetch_req_t                fetch_req,
    input  logic                      stall,
    input  logic                      flush,
    output logic                      ready,
    output logic                      resp_valid,
    output icache_resp_t              resp,
    // memory side
    output logic                      mem_req,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,
    input  logic                      addr_ok,
    input  logic                      data_ok,
    input  word_t                     mem_rdata
);

    icache_op_e              rbuf_op;
    index_t                  index;
    tag_t                    tag;
    logic [`ICACHE_WAYS-1:0] hit;
    logic [`ICACHE_WAYS-1:0] way_we;
    word_t                   way0_data;
    word_t                   way1_data;
    logic                    victim;
    logic                    rbuf_we;
    logic                    inv_set;
    logic                    use0;
    logic                    use1;
    logic                    sel_way;
    logic                    sel_refill;
    logic                    send_nop;

    icache_ctrl i_icache_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .flush       (flush),
        .ready       (ready),
        .rbuf_op     (rbuf_op),
        .hit         (hit),
        .victim      (victim),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .mem_req     (mem_req),
        .rbuf_we     (rbuf_we),
        .way_we      (way_we),
        .inv_set     (inv_set),
        .use0        (use0),
        .use1        (use1),
        .sel_way     (sel_way),
        .sel_refill  (sel_refill),
        .send_nop    (send_nop),
        .resp_valid  (resp_valid)
    );

    icache_req_buf i_icache_req_buf (
        .clk        (clk),
        .rstn       (rstn),
        .rbuf_we    (rbuf_we),
        .fetch_req  (fetch_req),
        .rbuf_op    (rbuf_op),
        .index      (index),
        .tag        (tag),
        .mem_addr   (mem_addr),
        .way0_data  (way0_data),
        .way1_data  (way1_data),
        .mem_rdata  (mem_rdata),
        .sel_way    (sel_way),
        .sel_refill (sel_refill),
        .send_nop   (send_nop),
        .resp       (resp)
    );

    icache_ways i_icache_ways (
        .clk       (clk),
        .rstn      (rstn),
        .index     (index),
        .tag       (tag),
        .mem_rdata (mem_rdata),
        .way_we    (way_we),
        .inv_set   (inv_set),
        .hit       (hit),
        .way0_data (way0_data),
        .way1_data (way1_data)
    );

    icache_lru i_icache_lru (
        .clk    (clk),
        .rstn   (rstn),
        .index  (index),
        .use0   (use0),
        .use1   (use1),
        .victim (victim)
    );

endmodule

// ==== logic/icache_ways.sv ====
`include "icache_config.svh"

module icache_ways
    import icache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  index_t                  index,
    input  tag_t                    tag,
    input  word_t                   mem_rdata,
    input  logic [`ICACHE_WAYS-1:0] way_we,
    input  logic                    inv_set,
    output logic [`ICACHE_WAYS-1:0] hit,
    output word_t                   way0_data,
    output word_t                   way1_data
);

    localparam int SETS = 1 << `ICACHE_INDEX_W;

    logic [SETS-1:0] valid_q  [`ICACHE_WAYS];
    tag_t            tag_mem  [`ICACHE_WAYS][SETS];
    word_t           data_mem [`ICACHE_WAYS][SETS];
    word_t           rd_data  [`ICACHE_WAYS];

    // valid bits, cleared on reset and by invalidate
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (inv_set) begin
                    valid_q[w][index] <= 1'b0;  // whole set
                end else if (way_we[w]) begin
                    valid_q[w][index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_we[w]) begin
                tag_mem[w][index]  <= tag;
                data_mem[w][index] <= mem_rdata;
            end
        end
    end

    // combinational read and tag compare
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit[w]     = valid_q[w][index] && (tag_mem[w][index] == tag);
            rd_data[w] = data_mem[w][index];
        end
    end

    assign way0_data = rd_data[0];
    assign way1_data = rd_data[1];

endmodule

// ==== sim.f ====
+incdir+logic
logic/icache_pkg.sv
logic/icache_ctrl.sv
logic/icache_req_buf.sv
logic/icache_ways.sv
logic/icache_lru.sv
logic/icache_top.sv
tb/icache_mem_model.sv
tb/icache_assert.sv
tb/icache_tb.sv

// ==== tb/icache_assert.sv ====
`include "icache_config.svh"

module icache_assert
    import icache_pkg::*;
(
    input logic                    clk,
    input logic                    rstn,
    input icache_state_e           state,
    input icache_state_e           next_state,
    input logic                    rbuf_we,
    input logic                    mem_req,
    input logic [`ICACHE_WAYS-1:0] way_we,
    input logic                    resp_valid
);

    int failures = 0;  // number of failed assertions

    // no memory traffic from an idle controller
    idle_no_req: assert property (@(posedge clk) disable iff (!rstn)
        state == ST_IDLE |-> !mem_req)
        else begin
            $error("mem_req is high while the controller is idle");
            failures++;
        end

    // at most one way written per refill
    way_we_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(way_we))
        else begin
            $error("more than one way written in the same cycle");
            failures++;
        end

    // a back to back hit restarts the lookup, which counts as a transition
    resp_with_move: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |-> (next_state != state) || rbuf_we)
        else begin
            $error("resp_valid without a state transition");
            failures++;
        end

endmodule

bind icache_ctrl icache_assert i_icache_assert (
    .clk        (clk),
    .rstn       (rstn),
    .state      (state),
    .next_state (next_state),
    .rbuf_we    (rbuf_we),
    .mem_req    (mem_req),
    .way_we     (way_we),
    .resp_valid (resp_valid)
);

// ==== tb/icache_mem_model.sv ====
`include "icache_config.svh"

module icache_mem_model #(
    parameter logic [31:0] KEY = 32'h5a3c96e1
) (
    input  logic                      clk,
    input  logic                      mem_req,
    input  logic [`ICACHE_ADDR_W-1:0] mem_addr,
    output logic                      addr_ok,
    output logic                      data_ok,
    output logic [31:0]               mem_rdata
);

    localparam int          DRIVE_DELAY = 2;
    localparam logic [31:0] SEED        = 32'hed9737c5;

    logic [31:0] lfsr;
    logic [31:0] addr;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    initial begin
        lfsr      = SEED;
        addr_ok   = 1'b0;
        data_ok   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (mem_req === 1'b1) begin
                addr = mem_addr;
                repeat (draw_bits(2)) @(posedge clk);  // addr_ok delay
                @(posedge clk);
                #DRIVE_DELAY;
                addr_ok = 1'b1;
                @(posedge clk);
                #DRIVE_DELAY;
                addr_ok = 1'b0;
                repeat (draw_bits(2)) @(posedge clk);
                #DRIVE_DELAY;
                data_ok   = 1'b1;
                mem_rdata = addr ^ KEY;  // word depends on the address only
                @(posedge clk);
                #DRIVE_DELAY;
                data_ok = 1'b0;
            end
        end
    end

endmodule

// ==== tb/icache_tb.sv ====
`include "icache_config.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int          DRIVE_DELAY = 2;
    localparam int          TIMEOUT     = 50;
    localparam logic [31:0] MEM_KEY     = 32'h5a3c96e1;

    logic                      clk;
    logic                      rstn;
    logic                      fetch_valid;
    fetch_req_t                fetch_req;
    logic                      stall;
    logic                      flush;
    logic                      ready;
    logic                      resp_valid;
    icache_resp_t              resp;
    logic                      mem_req;
    logic [`ICACHE_ADDR_W-1:0] mem_addr;
    logic                      addr_ok;
    logic                      data_ok;
    word_t                     mem_rdata;

    logic [31:0] lfsr;
    int          checks;
    int          errors;

    // reference copy of the cache contents
    logic        model_valid [2][16];
    tag_t        model_tag   [2][16];
    logic        model_lru   [16];  // 1 means way 1 is replaced next

    icache_top i_icache_top (.*);

    icache_mem_model #(.KEY(MEM_KEY)) i_icache_mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // four tags per set, so a set sees evictions
    function automatic logic [31:0] pick_addr(input index_t set_idx);
        tag_t tg;
        tg = tag_t'(32'h00abcd01 * (draw_bits(2) + 1));
        return {tg, set_idx, 2'b00};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_and_finish();
        errors += i_icache_top.i_icache_ctrl.i_icache_assert.failures;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("timeout: the cache never raised %s", what);
        report_and_finish();
    endtask

    // hold the request until the cache takes it
    task automatic send_request(input logic [31:0] addr, input icache_op_e op);
        int n;
        fetch_valid    = 1'b1;
        fetch_req.addr = addr;
        fetch_req.op   = op;
        @(negedge clk);
        for (n = 0; !ready; n++) begin
            if (n == TIMEOUT) begin
                give_up("ready");
            end
            @(negedge clk);
        end
        @(posedge clk);  // accept edge
        #DRIVE_DELAY;
        fetch_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // operations
    ////////////////////////////////////////////////////////////////////////////

    task automatic fetch_word(input logic [31:0] addr);
        index_t idx;
        tag_t   tg;
        logic   exp_hit;
        logic   way;
        logic   saw_req;
        int     n;
        idx     = addr[`ICACHE_INDEX_W+1:2];
        tg      = addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W+2];
        exp_hit = 1'b0;
        way     = 1'b0;
        saw_req = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == tg) begin
                exp_hit = 1'b1;
                way     = w[0];
            end
        end
        send_request(addr, OP_FETCH);
        @(negedge clk);
        for (n = 0; !resp_valid; n++) begin
            if (mem_req) begin
                saw_req = 1'b1;
                compare_value("mem_addr", mem_addr, addr);  // addresses are word aligned
            end
            if (n == TIMEOUT) begin
                give_up("resp_valid");
            end
            @(negedge clk);
        end
        saw_req |= mem_req;  // no request in the answer cycle either
        compare_value("resp.data", resp.data, {addr[31:2], 2'b00} ^ MEM_KEY);
        compare_value("resp.refill", resp.refill, !exp_hit);
        compare_value("resp.nop", resp.nop, 0);
        compare_value("mem_req", saw_req, !exp_hit);
        compare_value("data_ok", data_ok, !exp_hit);  // refill answers in the data_ok cycle
        if (exp_hit) begin
            compare_value("hit latency", n, 0);  // answer in the lookup cycle
            model_lru[idx] = (way == 1'b0);
        end else begin
            way                   = model_lru[idx];
            model_valid[way][idx] = 1'b1;
            model_tag[way][idx]   = tg;
            model_lru[idx]        = (way == 1'b0);
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic invalidate_set(input logic [31:0] addr);
        index_t idx;
        idx = addr[`ICACHE_INDEX_W+1:2];
        send_request(addr, OP_INVALIDATE);
        @(negedge clk);
        compare_value("resp_valid", resp_valid, 0);  // no answer for an op
        compare_value("mem_req", mem_req, 0);
        model_valid[0][idx] = 1'b0;
        model_valid[1][idx] = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic flush_lookup(input logic [31:0] addr, input int hold);
        flush = 1'b1;
        send_request(addr, OP_FETCH);
        fetch_valid = 1'b1;  // a pending request must not be taken
        for (int i = 0; i <= hold; i++) begin
            @(negedge clk);
            compare_value("ready", ready, 0);
            compare_value("mem_req", mem_req, 0);
            compare_value("resp_valid", resp_valid, i == 0);
            if (i == 0) begin
                compare_value("resp.nop", resp.nop, 1);
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        flush       = 1'b0;
        fetch_valid = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic hold_stall(input logic [31:0] addr, input int cycles);
        stall          = 1'b1;
        fetch_valid    = 1'b1;
        fetch_req.addr = addr;
        fetch_req.op   = OP_FETCH;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            compare_value("ready", ready, 0);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        stall       = 1'b0;
        fetch_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        index_t      set_idx;
        logic [31:0] addr;
        logic [3:0]  pick;
        rstn        = 1'b0;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        lfsr        = 32'hed9737c5;
        checks      = 0;
        errors      = 0;
        for (int s = 0; s < 16; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s]      = 1'b0;
        end
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        compare_value("ready", ready, 0);
        compare_value("mem_req", mem_req, 0);
        rstn = 1'b1;
        @(negedge clk);
        compare_value("ready", ready, 0);  // reset is still registered
        @(negedge clk);
        compare_value("ready", ready, 1);
        @(posedge clk);
        #DRIVE_DELAY;

        for (int i = 0; i < 400; i++) begin
            set_idx = index_t'(draw_bits(4));
            addr    = pick_addr(set_idx);
            pick    = draw_bits(4);
            if (pick == 4'd13) begin
                invalidate_set(addr);
                fetch_word(pick_addr(set_idx));  // must miss
            end else if (pick == 4'd14) begin
                flush_lookup(addr, draw_bits(2));
            end else if (pick == 4'd15) begin
                hold_stall(addr, 1 + draw_bits(2));
            end else begin
                fetch_word(addr);
            end
        end
        report_and_finish();
    end

endmodule
